// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_riscv_core
FLIST ?= riscv_core.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert --timescale 1ns/100ps

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with Verilator and run it"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: dv/riscv_core_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module riscv_core_asserts
  import riscv_pkg::*;
(
  input wire logic  clk,
  input wire logic  reset,
  input wire logic  mem_valid,
  input wire logic  mem_instr,
  input wire logic  mem_ready,
  input wire word_t mem_addr,
  input wire word_t mem_wdata,
  input wire strb_t mem_wstrb,
  input wire logic  trap
);

  addr_aligned: assert property (@(posedge clk) disable iff (reset)
    mem_valid |-> mem_addr[1:0] == 2'b00)
    else $error("mem_addr not word aligned");

  // a request may not change or drop until the memory accepts it
  req_held: assert property (@(posedge clk) disable iff (reset)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_wdata) &&
    $stable(mem_wstrb) && $stable(mem_instr))
    else $error("bus request changed before mem_ready");

  fetch_no_strb: assert property (@(posedge clk) disable iff (reset)
    mem_valid && mem_instr |-> mem_wstrb == '0)
    else $error("write strobes set during a fetch");

  halted_after_trap: assert property (@(posedge clk) disable iff (reset)
    trap |-> !$rose(mem_valid))
    else $error("bus request after trap");

endmodule

bind riscv_core riscv_core_asserts u_asserts (.*);

`default_nettype wire

// File: dv/tb_riscv_core.sv
`timescale 1ns/100ps
`default_nettype none
`include "riscv_defs.svh"

module tb_riscv_core
  import riscv_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 20000;
  localparam word_t DONE_ADDR = 32'h0000_03fc;
  localparam word_t DATA_WORD = 32'h8c7b_f6a5;

  logic clk, reset, mem_valid, mem_instr, mem_ready, trap;
  word_t mem_addr, mem_wdata, mem_rdata;
  strb_t mem_wstrb;

  word_t mem [0:1023];
  word_t prog[$], exp_q[$], fetch_q[$], st_addr[$], st_data[$];
  strb_t st_strb[$];
  logic done_seen, tx_seen, first_instr;
  word_t first_addr;
  int seed = 32'hfc1e;
  int wait_cnt, cycles;
  logic waiting;

  riscv_core DUT (.*);

  always #4 clk = ~clk;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "run stopped");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      fail_run("word mismatch");
    end
  endtask

  task automatic check_strb(input string name, input strb_t got, input strb_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
      fail_run("strobe mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
      fail_run("flag mismatch");
    end
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) fail_run("timeout, the core stopped making progress");
  end

  // memory answers after 0 to 3 wait cycles
  always @(negedge clk) begin
    if (reset || !mem_valid) begin
      mem_ready = 1'b0;
      waiting = 1'b0;
    end else if (!mem_ready) begin
      if (!waiting) begin
        wait_cnt = $unsigned($random(seed)) % 4;
        waiting = 1'b1;
      end
      if (wait_cnt == 0) begin
        mem_ready = 1'b1;
        mem_rdata = mem[mem_addr[11:2]];
        waiting = 1'b0;
      end else begin
        wait_cnt--;
      end
    end
  end

  always @(posedge clk) begin
    if (!reset && mem_valid && mem_ready) begin
      if (!tx_seen) begin
        first_instr = mem_instr;
        first_addr = mem_addr;
        tx_seen = 1'b1;
      end
      if (mem_instr && !done_seen) fetch_q.push_back(mem_addr);
      if (mem_wstrb != '0) begin
        for (int k = 0; k < 4; k++) begin
          if (mem_wstrb[k]) mem[mem_addr[11:2]][8*k +: 8] = mem_wdata[8*k +: 8];
        end
        st_addr.push_back(mem_addr);
        st_data.push_back(mem_wdata);
        st_strb.push_back(mem_wstrb);
        if (mem_addr == DONE_ADDR) done_seen = 1'b1;
      end
    end
  end

  function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                  input reg_addr_t rs1, input logic [2:0] f3,
                                  input reg_addr_t rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                  input logic [2:0] f3, input reg_addr_t rd,
                                  input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t enc_s(input logic [11:0] imm, input reg_addr_t rs2,
                                  input reg_addr_t rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic word_t enc_b(input logic [12:0] off, input reg_addr_t rs2,
                                  input reg_addr_t rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic word_t enc_j(input logic [20:0] off, input reg_addr_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic word_t pc_now();
    return word_t'(prog.size()) << 2;
  endfunction

  function automatic word_t sext8(input logic [7:0] v);
    return {{24{v[7]}}, v};
  endfunction

  function automatic word_t sext16(input logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  // branch outcome from the RV32I funct3 rules
  function automatic logic branch_rule(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
      3'b000: return a == b;
      3'b001: return a != b;
      3'b100: return $signed(a) < $signed(b);
      3'b101: return $signed(a) >= $signed(b);
      3'b110: return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic begin_prog();
    for (int i = 0; i < 1024; i++) mem[i] = 32'h5a5a_0000 ^ (word_t'(i) << 2);
    prog.delete();
    exp_q.delete();
  endtask

  // sw rs to the next result slot
  task automatic expect_reg(input reg_addr_t rs, input word_t value);
    prog.push_back(enc_s(12'(256 + 4 * exp_q.size()), rs, 5'd0, 3'b010));
    exp_q.push_back(value);
  endtask

  task automatic start_prog();
    foreach (prog[i]) mem[i] = prog[i];
    reset = 1'b1;
    repeat (10) @(negedge clk);
    fetch_q.delete();
    st_addr.delete();
    st_data.delete();
    st_strb.delete();
    done_seen = 1'b0;
    tx_seen = 1'b0;
    reset = 1'b0;
  endtask

  task automatic run_prog();
    prog.push_back(enc_s(DONE_ADDR[11:0], 5'd0, 5'd0, 3'b010));
    start_prog();
    while (!done_seen) begin
      @(negedge clk);
      if (trap) fail_run("unexpected trap while running a test program");
    end
    foreach (exp_q[i]) check_word($sformatf("result[%0d]", i), mem[64 + i], exp_q[i]);
  endtask

  task automatic test_alu();
    word_t a = 32'hffff_ffec;
    word_t b = 32'd3;
    word_t n = 32'hffff_ff00;
    begin_prog();
    prog.push_back(enc_i(12'hfec, 5'd0, 3'b000, 5'd1, 7'b0010011));
    prog.push_back(enc_i(12'h003, 5'd0, 3'b000, 5'd2, 7'b0010011));
    prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, 7'b0110011));
    expect_reg(5'd3, a + b);
    prog.push_back(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd3, 7'b0110011));
    expect_reg(5'd3, a - b);
    prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'b001, 5'd3, 7'b0110011));
    expect_reg(5'd3, a << 3);
    prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd3, 7'b0110011));
    expect_reg(5'd3, word_t'($signed(a) < $signed(b)));
    prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'b011, 5'd3, 7'b0110011));
    expect_reg(5'd3, word_t'(a < b));
    prog.push_back(enc_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd3, 7'b0110011));
    expect_reg(5'd3, word_t'($signed(b) < $signed(a)));
    prog.push_back(enc_r(7'h00, 5'd1, 5'd2, 3'b011, 5'd3, 7'b0110011));
    expect_reg(5'd3, word_t'(b < a));
    prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd3, 7'b0110011));
    expect_reg(5'd3, a ^ b);
    prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'b101, 5'd3, 7'b0110011));
    expect_reg(5'd3, a >> 3);
    prog.push_back(enc_r(7'h20, 5'd2, 5'd1, 3'b101, 5'd3, 7'b0110011));
    expect_reg(5'd3, word_t'($signed(a) >>> 3));
    prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd3, 7'b0110011));
    expect_reg(5'd3, a | b);
    prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd3, 7'b0110011));
    expect_reg(5'd3, a & b);
    prog.push_back(enc_i(12'h0a5, 5'd1, 3'b000, 5'd3, 7'b0010011));
    expect_reg(5'd3, a + 32'h0a5);
    prog.push_back(enc_i(12'h0a5, 5'd1, 3'b010, 5'd3, 7'b0010011));
    expect_reg(5'd3, word_t'($signed(a) < 32'sh0a5));
    prog.push_back(enc_i(12'hf00, 5'd1, 3'b011, 5'd3, 7'b0010011));
    expect_reg(5'd3, word_t'(a < n));
    prog.push_back(enc_i(12'hf00, 5'd1, 3'b100, 5'd3, 7'b0010011));
    expect_reg(5'd3, a ^ n);
    prog.push_back(enc_i(12'hf00, 5'd2, 3'b110, 5'd3, 7'b0010011));
    expect_reg(5'd3, b | n);
    prog.push_back(enc_i(12'hf00, 5'd1, 3'b111, 5'd3, 7'b0010011));
    expect_reg(5'd3, a & n);
    prog.push_back(enc_i(12'h005, 5'd1, 3'b001, 5'd3, 7'b0010011));
    expect_reg(5'd3, a << 5);
    prog.push_back(enc_i(12'h005, 5'd1, 3'b101, 5'd3, 7'b0010011));
    expect_reg(5'd3, a >> 5);
    prog.push_back(enc_i(12'h405, 5'd1, 3'b101, 5'd3, 7'b0010011));
    expect_reg(5'd3, word_t'($signed(a) >>> 5));
    run_prog();
    // straight-line code, so fetches must step by one word
    check_flag("first mem_instr", first_instr, 1'b1);
    check_word("first fetch addr", first_addr, `RESET_PC);
    foreach (fetch_q[i]) check_word("fetch addr", fetch_q[i], `RESET_PC + (word_t'(i) << 2));
  endtask

  task automatic test_flow();
    logic [2:0] conds [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    word_t p;
    word_t a = 32'hffff_ffec;
    begin_prog();
    // x6 only changes if a jump fails to skip its target
    prog.push_back(enc_i(12'h000, 5'd0, 3'b000, 5'd6, 7'b0010011));
    prog.push_back(enc_i(12'hfec, 5'd0, 3'b000, 5'd1, 7'b0010011));
    prog.push_back(enc_i(12'h003, 5'd0, 3'b000, 5'd2, 7'b0010011));
    prog.push_back({20'h12345, 5'd3, 7'b0110111});
    expect_reg(5'd3, 32'h1234_5000);
    p = pc_now();
    prog.push_back({20'h00001, 5'd3, 7'b0010111});
    expect_reg(5'd3, p + 32'h1000);
    p = pc_now();
    prog.push_back(enc_j(21'd8, 5'd5));
    prog.push_back(enc_i(12'h001, 5'd0, 3'b000, 5'd6, 7'b0010011));
    expect_reg(5'd5, p + 32'd4);
    p = pc_now();
    prog.push_back(enc_i(12'(p + 32'd12), 5'd0, 3'b000, 5'd7, 7'b0010011));
    prog.push_back(enc_i(12'h000, 5'd7, 3'b000, 5'd8, 7'b1100111));
    prog.push_back(enc_i(12'h002, 5'd0, 3'b000, 5'd6, 7'b0010011));
    expect_reg(5'd8, p + 32'd8);
    expect_reg(5'd6, 32'd0);
    // marker 2 means the branch skipped the marker 1 write
    for (int pass = 0; pass < 2; pass++) begin
      foreach (conds[i]) begin
        prog.push_back(enc_i(12'h002, 5'd0, 3'b000, 5'd9, 7'b0010011));
        prog.push_back(enc_b(13'd8, (pass == 0) ? 5'd2 : 5'd1, 5'd1, conds[i]));
        prog.push_back(enc_i(12'h001, 5'd0, 3'b000, 5'd9, 7'b0010011));
        expect_reg(5'd9, branch_rule(conds[i], a, (pass == 0) ? 32'd3 : a) ? 32'd2 : 32'd1);
      end
    end
    run_prog();
  endtask

  task automatic test_load_store();
    word_t sval = 32'h9abc_e000 + 32'hffff_ffef;
    logic [1:0] off;
    begin_prog();
    mem[32'h180 >> 2] = DATA_WORD;
    prog.push_back({20'h9abce, 5'd4, 7'b0110111});
    prog.push_back(enc_i(12'hfef, 5'd4, 3'b000, 5'd4, 7'b0010011));
    for (int k = 0; k < 4; k++) prog.push_back(enc_s(12'(12'h1c0 + k), 5'd4, 5'd0, 3'b000));
    prog.push_back(enc_s(12'h1c0, 5'd4, 5'd0, 3'b001));
    prog.push_back(enc_s(12'h1c2, 5'd4, 5'd0, 3'b001));
    for (int k = 0; k < 4; k++) begin
      prog.push_back(enc_i(12'(12'h180 + k), 5'd0, 3'b000, 5'd3, 7'b0000011));
      expect_reg(5'd3, sext8(DATA_WORD[8*k +: 8]));
      prog.push_back(enc_i(12'(12'h180 + k), 5'd0, 3'b100, 5'd3, 7'b0000011));
      expect_reg(5'd3, word_t'(DATA_WORD[8*k +: 8]));
    end
    for (int k = 0; k < 4; k += 2) begin
      prog.push_back(enc_i(12'(12'h180 + k), 5'd0, 3'b001, 5'd3, 7'b0000011));
      expect_reg(5'd3, sext16(DATA_WORD[8*k +: 16]));
      prog.push_back(enc_i(12'(12'h180 + k), 5'd0, 3'b101, 5'd3, 7'b0000011));
      expect_reg(5'd3, word_t'(DATA_WORD[8*k +: 16]));
    end
    prog.push_back(enc_i(12'h180, 5'd0, 3'b010, 5'd3, 7'b0000011));
    expect_reg(5'd3, DATA_WORD);
    run_prog();
    for (int k = 0; k < 6; k++) begin
      off = (k < 4) ? 2'(k) : 2'((k - 4) * 2);
      check_word("store addr", st_addr[k], 32'h1c0);
      if (k < 4) begin
        check_strb("mem_wstrb sb", st_strb[k], strb_t'(1) << off);
        check_word("sb lane", word_t'(st_data[k][8*off +: 8]), word_t'(sval[7:0]));
      end else begin
        check_strb("mem_wstrb sh", st_strb[k], strb_t'(3) << off);
        check_word("sh lane", word_t'(st_data[k][8*off +: 16]), word_t'(sval[15:0]));
      end
    end
    check_word("mem[0x1c0]", mem[32'h1c0 >> 2], {2{sval[15:0]}});
  endtask

  task automatic expect_trap(input string what);
    word_t fault_pc;
    fault_pc = pc_now() - 32'd4;
    start_prog();
    while (!trap) @(negedge clk);
    repeat (50) begin
      @(negedge clk);
      check_flag("trap", trap, 1'b1);
      check_flag("mem_valid", mem_valid, 1'b0);
    end
    // the faulting instruction is the last one fetched
    check_word({what, " fetch count"}, word_t'(fetch_q.size()), (fault_pc >> 2) + 32'd1);
    check_word({what, " last fetch"}, fetch_q[$], fault_pc);
  endtask

  task automatic test_traps();
    begin_prog();
    prog.push_back(enc_i(12'h005, 5'd0, 3'b000, 5'd1, 7'b0010011));
    prog.push_back(32'h0000_007f);
    expect_trap("invalid opcode");
    begin_prog();
    prog.push_back(enc_i(12'h002, 5'd0, 3'b010, 5'd3, 7'b0000011));
    expect_trap("misaligned lw");
    begin_prog();
    prog.push_back(enc_i(12'h022, 5'd0, 3'b000, 5'd7, 7'b0010011));
    prog.push_back(enc_i(12'h000, 5'd7, 3'b000, 5'd0, 7'b1100111));
    expect_trap("misaligned jalr");
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    mem_ready = 1'b0;
    mem_rdata = '0;
    cycles = 0;
    test_alu();
    test_flow();
    test_load_store();
    test_traps();
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu
  import riscv_pkg::*;
(
  input  alu_op_t      op,
  input  word_t        a,
  input  word_t        b,
  input  branch_cond_t cond,
  output word_t        result,
  output logic         taken
);

  logic lt_s;
  logic lt_u;
  logic eq;

  assign lt_s = $signed(a) < $signed(b);
  assign lt_u = a < b;
  assign eq = a == b;

  always_comb begin
    case (op)
      alu_sub: result = a - b;
      alu_sll: result = a << b[4:0];
      alu_slt: result = word_t'(lt_s);
      alu_sltu: result = word_t'(lt_u);
      alu_xor: result = a ^ b;
      alu_srl: result = a >> b[4:0];
      alu_sra: result = $signed(a) >>> b[4:0];
      alu_or: result = a | b;
      alu_and: result = a & b;
      default: result = a + b;
    endcase
  end

  always_comb begin
    case (cond)
      br_ne: taken = !eq;
      br_lt: taken = lt_s;
      br_ge: taken = !lt_s;
      br_ltu: taken = lt_u;
      br_geu: taken = !lt_u;
      default: taken = eq;
    endcase
  end

endmodule

`default_nettype wire

// File: logic/core_ctrl.sv
`timescale 1ns/100ps
`default_nettype none
`include "riscv_defs.svh"

module core_ctrl
  import riscv_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  mem_req_if.ctrl   mem,
  output word_t     instr,
  input  decoded_t  dec,
  output alu_op_t   alu_op,
  output word_t     alu_a,
  output word_t     alu_b,
  input  word_t     alu_result,
  input  logic      branch_taken,
  output reg_addr_t rs1_addr,
  output reg_addr_t rs2_addr,
  input  word_t     rs1_data,
  input  word_t     rs2_data,
  output logic      rd_we,
  output reg_addr_t rd_addr,
  output word_t     rd_data,
  output logic      trap
);

  typedef enum logic [2:0] {
    st_fetch, st_wait_fetch, st_decode, st_exec, st_wait_mem, st_writeback, st_trap
  } state_t;

  state_t state;
  word_t  pc;
  word_t  next_pc;
  word_t  op_a;
  word_t  op_b;
  word_t  pc_target;
  word_t  wb_data;
  word_t  link;
  word_t  ls_addr;
  word_t  jump_target;
  logic   is_jump;
  logic   is_mem;
  logic   ls_misaligned;
  logic   target_misaligned;
  logic   exec_fault;
  logic   mem_go;
  logic   writes_rd;

  assign link = pc + `INSTR_BYTES;
  assign ls_addr = op_a + dec.imm;
  // jalr drops bit 0 of its sum, jal and branches use pc + imm
  assign jump_target = (dec.iclass == class_jalr) ? {ls_addr[`XLEN-1:1], 1'b0} : pc_target;
  assign target_misaligned = jump_target[1:0] != 2'b00;

  assign is_jump = (dec.iclass == class_jal) || (dec.iclass == class_jalr);
  assign is_mem = (dec.iclass == class_load) || (dec.iclass == class_store);
  assign ls_misaligned = (dec.size == size_word) ? (ls_addr[1:0] != 2'b00) :
                         (dec.size == size_half) ? ls_addr[0] : 1'b0;

  assign exec_fault = (dec.iclass == class_invalid) ||
                      (is_jump && target_misaligned) ||
                      (dec.iclass == class_branch && branch_taken && target_misaligned) ||
                      (is_mem && ls_misaligned);

  assign mem_go = (state == st_exec) && is_mem && !ls_misaligned;
  assign writes_rd = (dec.iclass != class_branch) && (dec.iclass != class_store) &&
                     (dec.iclass != class_invalid);

  assign rs1_addr = dec.rs1;
  assign rs2_addr = dec.rs2;
  assign rd_addr = dec.rd;
  assign rd_we = (state == st_writeback) && writes_rd;
  assign rd_data = wb_data;

  assign alu_op = dec.alu_op;
  assign alu_a = op_a;
  assign alu_b = dec.use_imm ? dec.imm : op_b;

  assign mem.start = (state == st_fetch) || mem_go;
  assign mem.fetch = state == st_fetch;
  assign mem.store = mem_go && (dec.iclass == class_store);
  assign mem.size = dec.size;
  assign mem.is_unsigned = dec.load_unsigned;
  assign mem.addr = (state == st_fetch) ? pc : ls_addr;
  assign mem.wdata = op_b;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_fetch;
      pc <= `RESET_PC;
      trap <= 1'b0;
    end else begin
      case (state)
        st_fetch: state <= st_wait_fetch;
        st_wait_fetch: if (mem.done) state <= st_decode;
        st_decode: state <= st_exec;
        st_exec: begin
          if (exec_fault) begin
            state <= st_trap;
            trap <= 1'b1;
          end else begin
            state <= is_mem ? st_wait_mem : st_writeback;
          end
        end
        st_wait_mem: if (mem.done) state <= st_writeback;
        st_writeback: begin
          pc <= next_pc;
          state <= st_fetch;
        end
        // halted until reset
        default: state <= st_trap;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_wait_fetch && mem.done) instr <= mem.rdata;
    if (state == st_decode) begin
      op_a <= rs1_data;
      op_b <= rs2_data;
      pc_target <= pc + dec.imm;
    end
    if (state == st_exec) begin
      next_pc <= link;
      case (dec.iclass)
        class_lui: wb_data <= dec.imm;
        class_auipc: wb_data <= pc_target;
        class_jal, class_jalr: begin
          wb_data <= link;
          next_pc <= jump_target;
        end
        class_branch: if (branch_taken) next_pc <= jump_target;
        default: wb_data <= alu_result;
      endcase
    end
    if (state == st_wait_mem && mem.done) wb_data <= mem.rdata;
  end

endmodule

`default_nettype wire

// File: logic/instr_decode.sv
`timescale 1ns/100ps
`default_nettype none

module instr_decode
  import riscv_pkg::*;
(
  input  word_t    instr,
  output decoded_t dec
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       f7_zero;
  logic       f7_alt;
  logic       shift_op;
  logic       alu_ok;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign f7_zero = instr[31:25] == 7'b0000000;
  assign f7_alt = instr[31:25] == 7'b0100000;

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  // immediate shifts carry funct7 in the upper immediate bits
  assign shift_op = (funct3 == 3'b001) || (funct3 == 3'b101);
  assign alu_ok = opcode[5] ?
                  (f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101))) :
                  (!shift_op || f7_zero || (f7_alt && funct3 == 3'b101));

  always_comb begin
    dec = '0;
    dec.iclass = class_invalid;
    dec.alu_op = alu_add;
    dec.cond = br_eq;
    dec.rd = instr[11:7];
    dec.rs1 = instr[19:15];
    dec.rs2 = instr[24:20];
    dec.imm = imm_i;
    dec.size = mem_size_t'(funct3[1:0]);
    dec.load_unsigned = funct3[2];
    case (opcode)
      7'b0110111: begin
        dec.iclass = class_lui;
        dec.imm = imm_u;
      end
      7'b0010111: begin
        dec.iclass = class_auipc;
        dec.imm = imm_u;
      end
      7'b1101111: begin
        dec.iclass = class_jal;
        dec.imm = imm_j;
      end
      7'b1100111: begin
        if (funct3 == 3'b000) dec.iclass = class_jalr;
      end
      7'b1100011: begin
        dec.imm = imm_b;
        case (funct3)
          3'b000: dec.cond = br_eq;
          3'b001: dec.cond = br_ne;
          3'b100: dec.cond = br_lt;
          3'b101: dec.cond = br_ge;
          3'b110: dec.cond = br_ltu;
          default: dec.cond = br_geu;
        endcase
        if (funct3[2:1] != 2'b01) dec.iclass = class_branch;
      end
      7'b0000011: begin
        if (funct3 != 3'b011 && funct3[2:1] != 2'b11) dec.iclass = class_load;
      end
      7'b0100011: begin
        dec.imm = imm_s;
        if (funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b010) begin
          dec.iclass = class_store;
        end
      end
      7'b0010011, 7'b0110011: begin
        dec.use_imm = !opcode[5];
        case (funct3)
          3'b000: dec.alu_op = (opcode[5] && f7_alt) ? alu_sub : alu_add;
          3'b001: dec.alu_op = alu_sll;
          3'b010: dec.alu_op = alu_slt;
          3'b011: dec.alu_op = alu_sltu;
          3'b100: dec.alu_op = alu_xor;
          3'b101: dec.alu_op = f7_alt ? alu_sra : alu_srl;
          3'b110: dec.alu_op = alu_or;
          default: dec.alu_op = alu_and;
        endcase
        if (alu_ok) dec.iclass = class_alu;
      end
      // ecall, ebreak, fence and anything else fall through as invalid
      default: dec.iclass = class_invalid;
    endcase
  end

endmodule

`default_nettype wire

// File: logic/mem_port.sv
`timescale 1ns/100ps
`default_nettype none
`include "riscv_defs.svh"

module mem_port
  import riscv_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  mem_req_if.port mem,
  output logic    mem_valid,
  output logic    mem_instr,
  input  logic    mem_ready,
  output word_t   mem_addr,
  output word_t   mem_wdata,
  output strb_t   mem_wstrb,
  input  word_t   mem_rdata
);

  logic [1:0] lane;
  mem_size_t  size_q;
  logic       unsigned_q;
  logic       accept;
  logic       fire;
  logic       ext;
  word_t      lane_data;
  word_t      load_data;
  word_t      wdata_rep;
  strb_t      strb;

  assign accept = mem.start && !mem_valid;
  assign fire = mem_valid && mem_ready;

  // stores go out replicated, the strobes pick the lanes
  always_comb begin
    case (mem.size)
      size_byte: begin
        wdata_rep = {`WSTRB_W{mem.wdata[7:0]}};
        strb = strb_t'(1) << mem.addr[1:0];
      end
      size_half: begin
        wdata_rep = {(`WSTRB_W/2){mem.wdata[15:0]}};
        strb = strb_t'(2'b11) << {mem.addr[1], 1'b0};
      end
      default: begin
        wdata_rep = mem.wdata;
        strb = {`WSTRB_W{1'b1}};
      end
    endcase
  end

  // bring the addressed lane down to bit 0, then extend
  assign lane_data = mem_rdata >> {lane, 3'b000};

  always_comb begin
    case (size_q)
      size_byte: begin
        ext = !unsigned_q && lane_data[7];
        load_data = {{(`XLEN-8){ext}}, lane_data[7:0]};
      end
      size_half: begin
        ext = !unsigned_q && lane_data[15];
        load_data = {{(`XLEN-16){ext}}, lane_data[15:0]};
      end
      default: begin
        ext = 1'b0;
        load_data = lane_data;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_valid <= 1'b0;
      mem_instr <= 1'b0;
      mem_wstrb <= '0;
      mem.done <= 1'b0;
    end else begin
      mem.done <= fire;
      if (fire) begin
        mem_valid <= 1'b0;
        mem_wstrb <= '0;
      end else if (accept) begin
        mem_valid <= 1'b1;
        mem_instr <= mem.fetch;
        mem_wstrb <= mem.store ? strb : '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      mem_addr <= {mem.addr[`XLEN-1:2], 2'b00};
      mem_wdata <= wdata_rep;
      lane <= mem.addr[1:0];
      size_q <= mem.size;
      unsigned_q <= mem.is_unsigned;
    end
    if (fire) mem.rdata <= mem_instr ? mem_rdata : load_data;
  end

endmodule

`default_nettype wire

// File: logic/mem_req_if.sv
`timescale 1ns/100ps
`default_nettype none

interface mem_req_if
  import riscv_pkg::*;
();

  logic      start;
  logic      fetch;
  logic      store;
  mem_size_t size;
  logic      is_unsigned;
  word_t     addr;
  word_t     wdata;
  logic      done;
  word_t     rdata;

  modport ctrl (output start, fetch, store, size, is_unsigned, addr, wdata, input done, rdata);
  modport port (input start, fetch, store, size, is_unsigned, addr, wdata, output done, rdata);

endinterface

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/100ps
`default_nettype none
`include "riscv_defs.svh"

module reg_file
  import riscv_pkg::*;
(
  input  logic      clk,
  input  reg_addr_t rs1_addr,
  input  reg_addr_t rs2_addr,
  output word_t     rs1_data,
  output word_t     rs2_data,
  input  logic      we,
  input  reg_addr_t rd_addr,
  input  word_t     rd_data
);

  word_t regs [`REG_COUNT];

  always_ff @(posedge clk) begin
    if (we && rd_addr != '0) regs[rd_addr] <= rd_data;
  end

  // x0 is hardwired, its storage is never written
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// File: logic/riscv_core.sv
`timescale 1ns/100ps
`default_nettype none

module riscv_core
  import riscv_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  output logic  mem_valid,
  output logic  mem_instr,
  input  logic  mem_ready,
  output word_t mem_addr,
  output word_t mem_wdata,
  output strb_t mem_wstrb,
  input  word_t mem_rdata,
  output logic  trap
);

  word_t     instr;
  decoded_t  dec;
  alu_op_t   alu_op;
  word_t     alu_a;
  word_t     alu_b;
  word_t     alu_result;
  logic      branch_taken;
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  word_t     rs1_data;
  word_t     rs2_data;
  logic      rd_we;
  reg_addr_t rd_addr;
  word_t     rd_data;

  mem_req_if mem_bus ();

  core_ctrl u_ctrl (
    .clk, .reset, .mem(mem_bus.ctrl), .instr, .dec, .alu_op, .alu_a, .alu_b,
    .alu_result, .branch_taken, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
    .rd_we, .rd_addr, .rd_data, .trap
  );

  instr_decode u_decode (.instr, .dec);

  alu u_alu (
    .op(alu_op), .a(alu_a), .b(alu_b), .cond(dec.cond),
    .result(alu_result), .taken(branch_taken)
  );

  reg_file u_regs (
    .clk, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
    .we(rd_we), .rd_addr, .rd_data
  );

  mem_port u_mem (
    .clk, .reset, .mem(mem_bus.port), .mem_valid, .mem_instr, .mem_ready,
    .mem_addr, .mem_wdata, .mem_wstrb, .mem_rdata
  );

endmodule

`default_nettype wire

// File: logic/riscv_defs.svh
`ifndef RISCV_DEFS_SVH
`define RISCV_DEFS_SVH

// data path and address width
`define XLEN 32

// architectural register file
`define REG_COUNT 32
`define REG_ADDR_W 5

// byte lanes on the memory bus
`define WSTRB_W 4

// first fetch after reset
`define RESET_PC 32'h0000_0000

// every instruction is one full word
`define INSTR_BYTES 32'd4

`endif

// File: logic/riscv_pkg.sv
`default_nettype none
`include "riscv_defs.svh"

package riscv_pkg;

  typedef logic [`XLEN-1:0] word_t;
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [`WSTRB_W-1:0] strb_t;

  // encoding matches funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    size_byte = 2'b00,
    size_half = 2'b01,
    size_word = 2'b10
  } mem_size_t;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and
  } alu_op_t;

  typedef enum logic [2:0] {
    br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu
  } branch_cond_t;

  typedef enum logic [3:0] {
    class_lui, class_auipc, class_jal, class_jalr, class_branch,
    class_load, class_store, class_alu, class_invalid
  } instr_class_t;

  typedef struct packed {
    instr_class_t iclass;
    alu_op_t      alu_op;
    branch_cond_t cond;
    reg_addr_t    rd;
    reg_addr_t    rs1;
    reg_addr_t    rs2;
    word_t        imm;
    logic         use_imm;
    mem_size_t    size;
    logic         load_unsigned;
  } decoded_t;

endpackage

`default_nettype wire

// File: riscv_core.f
+incdir+logic
logic/riscv_pkg.sv
logic/mem_req_if.sv
logic/instr_decode.sv
logic/alu.sv
logic/reg_file.sv
logic/mem_port.sv
logic/core_ctrl.sv
logic/riscv_core.sv
dv/riscv_core_asserts.sv
dv/tb_riscv_core.sv
